//--- column_accumulator/bitplane_counter.sv
/*
 * Cross-lane popcount of every product bit position.
 * Counts are registered on advance as the first pipeline stage.
 * Each count is count_width(LANES) bits wide, position 0 in the low bits.
 */
`timescale 1ns/1ps
`default_nettype none

module bitplane_counter import pe_column_pkg::*; #(
	parameter int LANES = DEF_LANES,
	parameter int A_W = DEF_A_W,
	parameter int W_W = DEF_W_W
)(
	input  wire logic                                     CLK,
	input  wire logic                                     RESET,
	input  wire logic                                     advance,
	input  wire logic [LANES*(A_W+W_W)-1:0]               planes,
	output logic      [(A_W+W_W)*count_width(LANES)-1:0]  counts
);

	localparam int P_W = A_W + W_W;
	localparam int CNT_W = count_width(LANES);

	logic [P_W*CNT_W-1:0] counts_next;

	//////////////////////////////////////////////////////////////
	// one adder tree per bit plane
	//////////////////////////////////////////////////////////////
	for (genvar j = 0; j < P_W; j++) begin : g_plane
		logic [CNT_W-1:0] pop;

		always_comb begin
			pop = '0;
			// walk the lanes, picking bit j of each product
			for (int l = 0; l < LANES; l++) begin
				pop = pop + CNT_W'(planes[l*P_W + j]);
			end
		end

		assign counts_next[j*CNT_W +: CNT_W] = pop;
	end

	//////////////////////////////////////////////////////////////
	// stage 1 register
	//////////////////////////////////////////////////////////////
	always_ff @(posedge CLK) begin
		if (!RESET) begin
			counts <= '0;
		end else if (advance) begin
			counts <= counts_next;
		end
	end

endmodule

`default_nettype wire

//--- column_accumulator/position_decoder.sv
/*
 * Weights each plane count by 2**position and sums into the result.
 * The result is the exact unsigned dot product, registered on advance.
 * sum_width leaves room for the worst case of all operands at maximum.
 */
`timescale 1ns/1ps
`default_nettype none

module position_decoder import pe_column_pkg::*; #(
	parameter int LANES = DEF_LANES,
	parameter int A_W = DEF_A_W,
	parameter int W_W = DEF_W_W
)(
	input  wire logic                                     CLK,
	input  wire logic                                     RESET,
	input  wire logic                                     advance,
	input  wire logic [(A_W+W_W)*count_width(LANES)-1:0]  counts,
	output logic      [sum_width(LANES, A_W, W_W)-1:0]    result
);

	localparam int P_W = A_W + W_W;
	localparam int CNT_W = count_width(LANES);
	localparam int SUM_W = sum_width(LANES, A_W, W_W);

	logic [SUM_W-1:0] sum;

	//////////////////////////////////////////////////////////////
	// shift and add
	//////////////////////////////////////////////////////////////
	// every partial sum stays below the final dot product,
	// so the running total never wraps in SUM_W bits
	always_comb begin
		sum = '0;
		for (int j = 0; j < P_W; j++) begin
			sum = sum + (SUM_W'(counts[j*CNT_W +: CNT_W]) << j);
		end
	end

	//////////////////////////////////////////////////////////////
	// stage 2 register
	//////////////////////////////////////////////////////////////
	always_ff @(posedge CLK) begin
		if (!RESET) begin
			result <= '0;
		end else if (advance) begin
			result <= sum;
		end
	end

endmodule

`default_nettype wire

//--- common/pe_column_pkg.sv
/*
 * Default sizes and width helpers for the PE column.
 * Operands are unsigned. Widths hold the exact dot product with no rounding.
 */
`default_nettype none

package pe_column_pkg;

	//////////////////////////////////////////////////////////////
	// default column size
	//////////////////////////////////////////////////////////////
	parameter int DEF_LANES = 8;
	parameter int DEF_A_W = 8;
	parameter int DEF_W_W = 8;

	//////////////////////////////////////////////////////////////
	// width helpers
	//////////////////////////////////////////////////////////////

	// lane select, never narrower than one bit
	function automatic int addr_width(input int lanes);
		return (lanes > 1) ? $clog2(lanes) : 1;
	endfunction

	// popcount over lanes takes lanes + 1 values
	function automatic int count_width(input int lanes);
		return $clog2(lanes + 1);
	endfunction

	// product bits plus the growth of the lane sum
	function automatic int sum_width(input int lanes, input int a_w, input int w_w);
		return a_w + w_w + $clog2(lanes);
	endfunction

endpackage

`default_nettype wire

//--- logic/lane_array.sv
/*
 * Per-lane unsigned multipliers, each product shown as its bit planes.
 * Products are combinational from a and the stored weights.
 * a_right forwards the activations to the next column on advance.
 */
`timescale 1ns/1ps
`default_nettype none

module lane_array import pe_column_pkg::*; #(
	parameter int LANES = DEF_LANES,
	parameter int A_W = DEF_A_W,
	parameter int W_W = DEF_W_W
)(
	input  wire logic                          CLK,
	input  wire logic                          RESET,
	input  wire logic                          advance,
	input  wire logic [LANES*A_W-1:0]          a,
	input  wire logic [LANES*W_W-1:0]          weights,
	output logic      [LANES*(A_W+W_W)-1:0]    planes,
	output logic      [LANES*A_W-1:0]          a_right
);

	localparam int P_W = A_W + W_W;

	//////////////////////////////////////////////////////////////
	// multipliers
	//////////////////////////////////////////////////////////////
	for (genvar i = 0; i < LANES; i++) begin : g_mul
		logic [P_W-1:0] a_ext;
		logic [P_W-1:0] w_ext;

		assign a_ext = P_W'(a[i*A_W +: A_W]);
		assign w_ext = P_W'(weights[i*W_W +: W_W]);

		// bit k of this vector belongs to plane k
		assign planes[i*P_W +: P_W] = a_ext * w_ext;
	end

	//////////////////////////////////////////////////////////////
	// forwarding to the neighbour column
	//////////////////////////////////////////////////////////////
	always_ff @(posedge CLK) begin
		if (!RESET) begin
			a_right <= '0;
		end else if (advance) begin
			a_right <= a;
		end
	end

endmodule

`default_nettype wire

//--- logic/pe_column_top.sv
/*
 * One PE column of the bit-plane dot-product array.
 * result lags a by two advance edges, a_right by one.
 * en low or a load cycle freezes every pipeline register.
 */
`timescale 1ns/1ps
`default_nettype none

module pe_column_top import pe_column_pkg::*; #(
	parameter int LANES = DEF_LANES,
	parameter int A_W = DEF_A_W,
	parameter int W_W = DEF_W_W
)(
	input  wire logic                                   CLK,
	input  wire logic                                   RESET,
	input  wire logic                                   en,
	input  wire logic                                   load_en,
	input  wire logic [addr_width(LANES)-1:0]           address,
	input  wire logic [W_W-1:0]                         w,
	input  wire logic [LANES*A_W-1:0]                   a,
	output logic      [LANES*A_W-1:0]                   a_right,
	output logic      [sum_width(LANES, A_W, W_W)-1:0]  result
);

	localparam int P_W = A_W + W_W;
	localparam int CNT_W = count_width(LANES);

	logic [LANES*W_W-1:0] weights;
	logic                 advance;
	logic [LANES*P_W-1:0] planes;
	logic [P_W*CNT_W-1:0] counts;

	//////////////////////////////////////////////////////////////
	// weights and control
	//////////////////////////////////////////////////////////////
	weight_bank #(
		.LANES(LANES),
		.W_W(W_W)
	) weight_bank_i (
		.CLK(CLK),
		.RESET(RESET),
		.en(en),
		.load_en(load_en),
		.address(address),
		.w(w),
		.weights(weights),
		.advance(advance)
	);

	lane_array #(
		.LANES(LANES),
		.A_W(A_W),
		.W_W(W_W)
	) lane_array_i (
		.CLK(CLK),
		.RESET(RESET),
		.advance(advance),
		.a(a),
		.weights(weights),
		.planes(planes),
		.a_right(a_right)
	);

	//////////////////////////////////////////////////////////////
	// accumulation pipeline
	//////////////////////////////////////////////////////////////
	bitplane_counter #(
		.LANES(LANES),
		.A_W(A_W),
		.W_W(W_W)
	) bitplane_counter_i (
		.CLK(CLK),
		.RESET(RESET),
		.advance(advance),
		.planes(planes),
		.counts(counts)
	);

	position_decoder #(
		.LANES(LANES),
		.A_W(A_W),
		.W_W(W_W)
	) position_decoder_i (
		.CLK(CLK),
		.RESET(RESET),
		.advance(advance),
		.counts(counts),
		.result(result)
	);

endmodule

`default_nettype wire

//--- logic/weight_bank.sv
/*
 * Addressed weight registers and the column's advance strobe.
 * A write lands one edge after the load cycle.
 * Addresses at or above LANES match no lane and write nothing.
 */
`timescale 1ns/1ps
`default_nettype none

module weight_bank import pe_column_pkg::*; #(
	parameter int LANES = DEF_LANES,
	parameter int W_W = DEF_W_W
)(
	input  wire logic                          CLK,
	input  wire logic                          RESET,
	input  wire logic                          en,
	input  wire logic                          load_en,
	input  wire logic [addr_width(LANES)-1:0]  address,
	input  wire logic [W_W-1:0]                w,
	output logic      [LANES*W_W-1:0]          weights,
	output logic                               advance
);

	localparam int ADDR_W = addr_width(LANES);

	logic wr;

	// a load cycle freezes the pipeline, so the two are exclusive
	assign wr = en & load_en;
	assign advance = en & ~load_en;

	for (genvar i = 0; i < LANES; i++) begin : g_lane
		logic [W_W-1:0] w_q;

		always_ff @(posedge CLK) begin
			if (!RESET) begin
				w_q <= '0;
			end else if (wr && address == ADDR_W'(i)) begin
				w_q <= w;
			end
		end

		assign weights[i*W_W +: W_W] = w_q;
	end

endmodule

`default_nettype wire

//--- pe_column.f
common/pe_column_pkg.sv
logic/weight_bank.sv
logic/lane_array.sv
column_accumulator/bitplane_counter.sv
column_accumulator/position_decoder.sv
logic/pe_column_top.sv
tests/pe_column_checker.sv
tests/pe_column_properties.sv
tests/pe_column_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the PE column testbench with Verilator.
# The exit status is zero only when the run prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module pe_column_tb \
	-f pe_column.f -o pe_column_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/pe_column_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
else
	echo "pass line not found in simulation output"
	exit 1
fi

//--- tests/pe_column_checker.sv
/*
 * Watches the top-level ports and predicts result and a_right.
 * Keeps its own weight table and a two-deep expected pipeline.
 * Compares on the falling edge, once the first reset edge is seen.
 */
`timescale 1ns/1ps
`default_nettype none

module pe_column_checker import pe_column_pkg::*; #(
	parameter int LANES = DEF_LANES,
	parameter int A_W = DEF_A_W,
	parameter int W_W = DEF_W_W
)(
	input  wire logic                                   CLK,
	input  wire logic                                   RESET,
	input  wire logic                                   en,
	input  wire logic                                   load_en,
	input  wire logic [addr_width(LANES)-1:0]           address,
	input  wire logic [W_W-1:0]                         w,
	input  wire logic [LANES*A_W-1:0]                   a,
	input  wire logic [LANES*A_W-1:0]                   a_right,
	input  wire logic [sum_width(LANES, A_W, W_W)-1:0]  result,
	output int                                          checks,
	output int                                          errors
);

	localparam int SUM_W = sum_width(LANES, A_W, W_W);

	logic [W_W-1:0]       shadow_w [LANES];
	logic [SUM_W-1:0]     exp_stage1;
	logic [SUM_W-1:0]     exp_result;
	logic [LANES*A_W-1:0] exp_a_right;
	logic                 armed = 1'b0;
	int                   n_checks = 0;
	int                   n_errors = 0;

	assign checks = n_checks;
	assign errors = n_errors;

	// sum of a[l] * w[l] over all lanes, unsigned and exact
	function automatic logic [SUM_W-1:0] dot_product(
		input logic [LANES*A_W-1:0] acts,
		input logic [W_W-1:0]       wts [LANES]
	);
		logic [SUM_W-1:0] acc;
		acc = '0;
		for (int l = 0; l < LANES; l++) begin
			acc = acc + SUM_W'(acts[l*A_W +: A_W]) * SUM_W'(wts[l]);
		end
		return acc;
	endfunction

	//////////////////////////////////////////////////////////////
	// model update on the rising edge
	//////////////////////////////////////////////////////////////
	always @(posedge CLK) begin
		if (!RESET) begin
			for (int l = 0; l < LANES; l++) begin
				shadow_w[l] = '0;
			end
			exp_stage1 = '0;
			exp_result = '0;
			exp_a_right = '0;
			armed = 1'b1;
		end else if (en && load_en) begin
			if (int'(address) < LANES) begin
				shadow_w[address] = w;
			end
		end else if (en) begin
			exp_result = exp_stage1;
			exp_stage1 = dot_product(a, shadow_w);
			exp_a_right = a;
		end
	end

	//////////////////////////////////////////////////////////////
	// compare while outputs are settled
	//////////////////////////////////////////////////////////////
	always @(negedge CLK) begin
		if (armed) begin
			n_checks = n_checks + 2;
			if (result !== exp_result) begin
				$display("error t=%0t result expected %0h actual %0h",
					$time, exp_result, result);
				n_errors = n_errors + 1;
			end
			if (a_right !== exp_a_right) begin
				$display("error t=%0t a_right expected %0h actual %0h",
					$time, exp_a_right, a_right);
				n_errors = n_errors + 1;
			end
		end
	end

endmodule

`default_nettype wire

//--- tests/pe_column_properties.sv
/*
 * Concurrent properties on the PE column outputs, bound to the top level.
 * Covers reset clearing, hold with en low, and hold of result on loads.
 */
`timescale 1ns/1ps
`default_nettype none

module pe_column_properties import pe_column_pkg::*; #(
	parameter int LANES = DEF_LANES,
	parameter int A_W = DEF_A_W,
	parameter int W_W = DEF_W_W
)(
	input  wire logic                                   CLK,
	input  wire logic                                   RESET,
	input  wire logic                                   en,
	input  wire logic                                   load_en,
	input  wire logic [LANES*A_W-1:0]                   a_right,
	input  wire logic [sum_width(LANES, A_W, W_W)-1:0]  result
);

	reset_clears: assert property (@(posedge CLK)
		!RESET |=> (result == '0 && a_right == '0))
		else $error("outputs not cleared by reset");

	// no edge with en low may move the outputs
	idle_holds: assert property (@(posedge CLK) disable iff (!RESET)
		!en |=> ($stable(result) && $stable(a_right)))
		else $error("outputs moved while en was low");

	load_holds: assert property (@(posedge CLK) disable iff (!RESET)
		(en && load_en) |=> $stable(result))
		else $error("result moved during a weight load");

endmodule

bind pe_column_top pe_column_properties #(
	.LANES(LANES),
	.A_W(A_W),
	.W_W(W_W)
) properties_i (
	.CLK(CLK),
	.RESET(RESET),
	.en(en),
	.load_en(load_en),
	.a_right(a_right),
	.result(result)
);

`default_nettype wire

//--- tests/pe_column_tb.sv
/*
 * Testbench for the PE column at the package default sizes.
 * Inputs change on the falling edge, the checker compares every cycle.
 * Out-of-range loads only run when LANES leaves unused addresses.
 */
`timescale 1ns/1ps
`default_nettype none

module pe_column_tb import pe_column_pkg::*; ();

	localparam int LANES = DEF_LANES;
	localparam int A_W = DEF_A_W;
	localparam int W_W = DEF_W_W;
	localparam int ADDR_W = addr_width(LANES);
	localparam int SUM_W = sum_width(LANES, A_W, W_W);
	localparam int STREAM_SETS = 50;
	localparam int STALL_SETS = 40;
	localparam int RESULT_TIMEOUT = 10;
	localparam int WATCHDOG_NS = 200000;

	logic                 CLK;
	logic                 RESET;
	logic                 en;
	logic                 load_en;
	logic [ADDR_W-1:0]    address;
	logic [W_W-1:0]       w;
	logic [LANES*A_W-1:0] a;
	logic [LANES*A_W-1:0] a_right;
	logic [SUM_W-1:0]     result;
	int                   checks;
	int                   errors;

	int seed;
	int tb_errors;
	int err_mark;
	int tests_passed;
	int tests_failed;

	pe_column_top #(
		.LANES(LANES),
		.A_W(A_W),
		.W_W(W_W)
	) dut_i (
		.CLK(CLK),
		.RESET(RESET),
		.en(en),
		.load_en(load_en),
		.address(address),
		.w(w),
		.a(a),
		.a_right(a_right),
		.result(result)
	);

	pe_column_checker #(
		.LANES(LANES),
		.A_W(A_W),
		.W_W(W_W)
	) checker_i (
		.CLK(CLK),
		.RESET(RESET),
		.en(en),
		.load_en(load_en),
		.address(address),
		.w(w),
		.a(a),
		.a_right(a_right),
		.result(result),
		.checks(checks),
		.errors(errors)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("CHECKS FAILED");
		$finish;
	end

	//////////////////////////////////////////////////////////////
	// stimulus helpers, each entered and left on a falling edge
	//////////////////////////////////////////////////////////////
	function automatic logic [LANES*A_W-1:0] random_acts();
		logic [LANES*A_W-1:0] acts;
		for (int l = 0; l < LANES; l++) begin
			acts[l*A_W +: A_W] = A_W'($random(seed));
		end
		return acts;
	endfunction

	task automatic load_weight(input int lane, input logic [W_W-1:0] value);
		en = 1'b1;
		load_en = 1'b1;
		address = ADDR_W'(lane);
		w = value;
		@(negedge CLK);
		load_en = 1'b0;
		en = 1'b0;
	endtask

	task automatic stream_set(input logic [LANES*A_W-1:0] acts);
		en = 1'b1;
		a = acts;
		@(negedge CLK);
		en = 1'b0;
	endtask

	// a keeps changing here, the column must ignore it
	task automatic stall(input int cycles);
		en = 1'b0;
		for (int c = 0; c < cycles; c++) begin
			a = random_acts();
			@(negedge CLK);
		end
	endtask

	// advance with a fixed a until result reaches the target
	task automatic wait_result(input logic [LANES*A_W-1:0] acts,
		input logic [SUM_W-1:0] target);
		int n;
		n = 0;
		en = 1'b1;
		a = acts;
		while (result !== target && n < RESULT_TIMEOUT) begin
			@(negedge CLK);
			n++;
		end
		en = 1'b0;
		if (result !== target) begin
			$display("error t=%0t result expected %0h actual %0h", $time, target, result);
			tb_errors++;
		end
	endtask

	task automatic end_test(input string name);
		int new_errors;
		new_errors = errors + tb_errors - err_mark;
		err_mark = errors + tb_errors;
		if (new_errors == 0) begin
			tests_passed++;
			$display("test %s passed", name);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", name, new_errors);
		end
	endtask

	//////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////
	initial begin
		logic [SUM_W-1:0] max_dot;
		int lane;
		seed = 85;
		tb_errors = 0;
		err_mark = 0;
		tests_passed = 0;
		tests_failed = 0;
		RESET = 1'b0;
		en = 1'b0;
		load_en = 1'b0;
		address = '0;
		w = '0;
		a = '0;

		for (int c = 0; c < 10; c++) begin
			@(negedge CLK);
		end
		RESET = 1'b1;
		@(negedge CLK);
		end_test("reset");

		for (int l = 0; l < LANES; l++) begin
			load_weight(l, W_W'($random(seed)));
		end
		for (int s = 0; s < STREAM_SETS; s++) begin
			stream_set(random_acts());
		end
		end_test("load and stream");

		for (int s = 0; s < STALL_SETS; s++) begin
			stream_set(random_acts());
			if ($unsigned($random(seed)) % 5 == 0) begin
				stall(2 + int'($unsigned($random(seed)) % 5));
			end
		end
		end_test("stalls");

		stream_set(random_acts());
		stream_set(random_acts());
		lane = int'($unsigned($random(seed)) % LANES);
		load_weight(lane, W_W'($random(seed)));
		if ((1 << ADDR_W) > LANES) begin
			load_weight(LANES, W_W'($random(seed)));
		end else begin
			$display("note: every %0d-bit address selects a lane", ADDR_W);
		end
		stream_set(random_acts());
		stream_set(random_acts());
		stream_set('0);
		stream_set('0);
		end_test("reload");

		// worst case is LANES * (2**A_W - 1) * (2**W_W - 1)
		max_dot = SUM_W'(LANES) * SUM_W'({A_W{1'b1}}) * SUM_W'({W_W{1'b1}});
		for (int l = 0; l < LANES; l++) begin
			load_weight(l, '1);
		end
		wait_result('1, max_dot);
		wait_result('0, '0);
		end_test("extremes");

		// reset with a full pipeline clears the outputs and every weight
		stream_set(random_acts());
		stream_set(random_acts());
		RESET = 1'b0;
		for (int c = 0; c < 3; c++) begin
			@(negedge CLK);
		end
		RESET = 1'b1;
		@(negedge CLK);
		stream_set(random_acts());
		stream_set(random_acts());
		end_test("reset in mid-stream");

		$display("tests passed %0d failed %0d, checks %0d, errors %0d",
			tests_passed, tests_failed, checks, errors + tb_errors);
		if (tests_failed == 0 && errors + tb_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
